//--- source/window_filter_pkg.sv
`default_nettype none

package window_filter_pkg;

  // ##################################################
  // image and window geometry.
  // ##################################################
  localparam int IMG_COLS = 8;
  localparam int IMG_ROWS = 6;
  localparam int WIN      = 3;

  localparam int PIX_W = 8;
  localparam int RES_W = PIX_W + $clog2(WIN * WIN); // full window sum fits.

  localparam int COL_W = $clog2(IMG_COLS);
  localparam int ROW_W = $clog2(IMG_ROWS);

  // ##################################################
  // shared types.
  // ##################################################
  typedef logic [PIX_W-1:0] pix_t;
  typedef logic [RES_W-1:0] res_t;  // min and max are zero-extended.

  typedef enum logic [1:0] {
    OP_SUM = 2'd0,
    OP_MAX = 2'd1,
    OP_MIN = 2'd2
  } op_e;

  // idle until the first pixel of a frame arrives.
  typedef enum logic {
    ST_IDLE  = 1'b0,
    ST_FRAME = 1'b1
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- source/window_ctrl.sv
`default_nettype none

module window_ctrl
  import window_filter_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             pix_valid_i,
  input  logic             pix_ready_i,
  input  op_e              op_i,
  output logic             accept_o,
  output logic [COL_W-1:0] col_idx_o,
  output logic             win_ok_o,
  output op_e              frame_op_o
);

  ctrl_state_e      state_q;
  logic [COL_W-1:0] col_q;
  logic [ROW_W-1:0] row_q;
  op_e              op_q;
  logic             col_last;
  logic             row_last;

  assign accept_o = pix_valid_i & pix_ready_i;

  assign col_last = (col_q == COL_W'(IMG_COLS - 1));
  assign row_last = (row_q == ROW_W'(IMG_ROWS - 1));

  // ##################################################
  // raster counters and frame state.
  // ##################################################
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      col_q   <= '0;
      row_q   <= '0;
    end else if (accept_o) begin
      if (state_q == ST_IDLE) begin
        state_q <= ST_FRAME;
      end
      if (col_last) begin
        col_q <= '0;
        if (row_last) begin
          row_q   <= '0;
          state_q <= ST_IDLE;  // last pixel of the frame.
        end else begin
          row_q <= row_q + 1'b1;
        end
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // opcode is taken with the first pixel only.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op_q <= OP_SUM;
    end else if (accept_o && (state_q == ST_IDLE)) begin
      op_q <= op_i;
    end
  end

  // the first pixel sees op_i directly.
  assign frame_op_o = (state_q == ST_IDLE) ? op_i : op_q;

  assign col_idx_o = col_q;

  // bottom-right corner of a full window.
  assign win_ok_o = (col_q >= COL_W'(WIN - 1)) &&
                    (row_q >= ROW_W'(WIN - 1));

endmodule

`default_nettype wire

//--- source/line_buffer_bank.sv
`default_nettype none

module line_buffer_bank
  import window_filter_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             accept_i,
  input  logic             adv_i,
  input  logic [COL_W-1:0] col_idx_i,
  input  pix_t             pix_i,
  output pix_t             col_pix_o [WIN],
  output logic             col_valid_o
);

  // row memories, index 0 holds the oldest row.
  pix_t mem [WIN-1][IMG_COLS];

  pix_t col_q [WIN];
  logic col_valid_q;

  // ##################################################
  // column read and row shift at col_idx_i.
  // ##################################################
  always_ff @(posedge clk) begin
    if (accept_i) begin
      for (int r = 0; r < WIN - 1; r++) begin
        col_q[r] <= mem[r][col_idx_i];
      end
      col_q[WIN-1] <= pix_i;  // newest row comes straight from the stream.

      // each stored row moves one step older.
      for (int r = 0; r < WIN - 2; r++) begin
        mem[r][col_idx_i] <= mem[r+1][col_idx_i];
      end
      mem[WIN-2][col_idx_i] <= pix_i;
    end
  end

  // marks a fresh column for the row chains.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_valid_q <= 1'b0;
    end else if (adv_i) begin
      col_valid_q <= accept_i;
    end
  end

  always_comb begin
    for (int r = 0; r < WIN; r++) begin
      col_pix_o[r] = col_q[r];
    end
  end

  assign col_valid_o = col_valid_q;

endmodule

`default_nettype wire

//--- source/window_row.sv
`default_nettype none

module window_row
  import window_filter_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic adv_i,
  input  logic col_valid_i,
  input  pix_t pix_i,
  output res_t row_sum_o,
  output pix_t row_max_o,
  output pix_t row_min_o
);

  pix_t taps [WIN];
  res_t sum_c;
  pix_t max_c;
  pix_t min_c;
  res_t sum_q;
  pix_t max_q;
  pix_t min_q;

  // tap 0 is the newest column.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < WIN; k++) begin
        taps[k] <= '0;
      end
    end else if (adv_i && col_valid_i) begin
      taps[0] <= pix_i;
      for (int k = 1; k < WIN; k++) begin
        taps[k] <= taps[k-1];
      end
    end
  end

  always_comb begin
    sum_c = '0;
    max_c = taps[0];
    min_c = taps[0];
    for (int k = 0; k < WIN; k++) begin
      sum_c = sum_c + RES_W'(taps[k]);
      if (taps[k] > max_c) max_c = taps[k];
      if (taps[k] < min_c) min_c = taps[k];
    end
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      sum_q <= sum_c;
      max_q <= max_c;
      min_q <= min_c;
    end
  end

  assign row_sum_o = sum_q;
  assign row_max_o = max_q;
  assign row_min_o = min_q;

endmodule

`default_nettype wire

//--- source/window_reduce.sv
`default_nettype none

module window_reduce
  import window_filter_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic res_ready_i,
  input  logic win_ok_i,
  input  op_e  frame_op_i,
  input  logic accept_i,
  input  res_t row_sum_i [WIN],
  input  pix_t row_max_i [WIN],
  input  pix_t row_min_i [WIN],
  output logic adv_o,
  output logic res_valid_o,
  output res_t res_o
);

  logic [2:0] tag_q;  // one bit per stage, column, chain, partials.
  op_e        op_q [3];
  res_t       sum_acc;
  pix_t       max_acc;
  pix_t       min_acc;
  res_t       res_c;
  logic       valid_q;
  res_t       res_q;

  assign adv_o = !valid_q || res_ready_i;

  // ##################################################
  // tag and opcode pipe, in step with the datapath.
  // ##################################################
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tag_q <= '0;
    end else if (adv_o) begin
      tag_q <= {tag_q[1:0], accept_i & win_ok_i};
    end
  end

  always_ff @(posedge clk) begin
    if (adv_o) begin
      op_q[0] <= frame_op_i;
      op_q[1] <= op_q[0];
      op_q[2] <= op_q[1];
    end
  end

  always_comb begin
    sum_acc = '0;
    max_acc = row_max_i[0];
    min_acc = row_min_i[0];
    for (int r = 0; r < WIN; r++) begin
      sum_acc = sum_acc + row_sum_i[r];
      if (row_max_i[r] > max_acc) max_acc = row_max_i[r];
      if (row_min_i[r] < min_acc) min_acc = row_min_i[r];
    end
    case (op_q[2])
      OP_MAX:  res_c = RES_W'(max_acc);
      OP_MIN:  res_c = RES_W'(min_acc);
      default: res_c = sum_acc;
    endcase
  end

  // output register, holds while the sink stalls.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (adv_o) begin
      valid_q <= tag_q[2];
    end
  end

  always_ff @(posedge clk) begin
    if (adv_o && tag_q[2]) res_q <= res_c;
  end

  assign res_valid_o = valid_q;
  assign res_o       = res_q;

endmodule

`default_nettype wire

//--- source/window_filter_top.sv
`default_nettype none

module window_filter_top
  import window_filter_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic pix_valid_i,
  input  pix_t pix_i,
  input  op_e  op_i,
  input  logic res_ready_i,
  output logic pix_ready_o,
  output logic res_valid_o,
  output res_t res_o
);

  logic             adv;
  logic             accept;
  logic [COL_W-1:0] col_idx;
  logic             win_ok;
  op_e              frame_op;
  pix_t             col_pix [WIN];
  logic             col_valid;
  res_t             row_sum [WIN];
  pix_t             row_max [WIN];
  pix_t             row_min [WIN];

  assign pix_ready_o = adv;  // input stalls with the whole pipe.

  window_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_valid_i (pix_valid_i),
    .pix_ready_i (adv),
    .op_i        (op_i),
    .accept_o    (accept),
    .col_idx_o   (col_idx),
    .win_ok_o    (win_ok),
    .frame_op_o  (frame_op)
  );

  line_buffer_bank u_lbuf (
    .clk         (clk),
    .rst_n       (rst_n),
    .accept_i    (accept),
    .adv_i       (adv),
    .col_idx_i   (col_idx),
    .pix_i       (pix_i),
    .col_pix_o   (col_pix),
    .col_valid_o (col_valid)
  );

  // ##################################################
  // one shift chain per window row.
  // ##################################################
  for (genvar r = 0; r < WIN; r++) begin : g_row
    window_row u_row (
      .clk         (clk),
      .rst_n       (rst_n),
      .adv_i       (adv),
      .col_valid_i (col_valid),
      .pix_i       (col_pix[r]),
      .row_sum_o   (row_sum[r]),
      .row_max_o   (row_max[r]),
      .row_min_o   (row_min[r])
    );
  end

  window_reduce u_reduce (
    .clk         (clk),
    .rst_n       (rst_n),
    .res_ready_i (res_ready_i),
    .win_ok_i    (win_ok),
    .frame_op_i  (frame_op),
    .accept_i    (accept),
    .row_sum_i   (row_sum),
    .row_max_i   (row_max),
    .row_min_i   (row_min),
    .adv_o       (adv),
    .res_valid_o (res_valid_o),
    .res_o       (res_o)
  );

endmodule

`default_nettype wire

//--- test/tb_window_filter.sv
`default_nettype none

module tb_window_filter
  import window_filter_pkg::*;
();

  localparam int CLK_PERIOD  = 100;
  localparam int SEED        = 29;
  localparam int OUT_COLS    = IMG_COLS - WIN + 1;
  localparam int OUT_ROWS    = IMG_ROWS - WIN + 1;
  localparam int RES_PER_FRM = OUT_COLS * OUT_ROWS;
  localparam int PIX_PER_FRM = IMG_COLS * IMG_ROWS;
  localparam int N_FRAMES    = 3;
  localparam int N_PASSES    = 2;  // clean stream, then gaps and stalls.
  localparam int N_STREAM    = N_PASSES * N_FRAMES;
  localparam int FRM_WORDS   = 1 + PIX_PER_FRM + RES_PER_FRM;
  localparam int CASE_WORDS  = N_FRAMES * FRM_WORDS;
  localparam int TOTAL_PIX   = N_STREAM * PIX_PER_FRM;
  localparam int TOTAL_RES   = N_STREAM * RES_PER_FRM;
  localparam int FIRST_WIN   = (WIN - 1) * IMG_COLS + (WIN - 1);
  localparam int WD_CYCLES   = TOTAL_PIX * 4 + 400;

  logic clk;
  logic rst_n;
  logic pix_valid_i;
  pix_t pix_i;
  op_e  op_i;
  logic res_ready_i;
  logic pix_ready_o;
  logic res_valid_o;
  res_t res_o;

  logic [RES_W-1:0] case_mem [CASE_WORDS];
  op_e              frame_op [N_FRAMES];
  pix_t             frame_pix [N_FRAMES][PIX_PER_FRM];
  res_t             frame_exp [N_FRAMES][RES_PER_FRM];

  int   accepted;
  int   received;
  int   frame_res [N_STREAM];
  logic stall_on;
  logic sent_done;
  logic done_all;
  logic held;
  res_t held_res;
  int   val_errs;
  int   cnt_errs;
  int   flag_errs;
  int   other_errs;

  window_filter_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_valid_i (pix_valid_i),
    .pix_i       (pix_i),
    .op_i        (op_i),
    .res_ready_i (res_ready_i),
    .pix_ready_o (pix_ready_o),
    .res_valid_o (res_valid_o),
    .res_o       (res_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ##################################################
  // compare tasks.
  // ##################################################
  task automatic check_res(res_t got, res_t exp, string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_count(int got, int exp, string what);
    if (got != exp) begin
      $display("[ERROR] %0t: %s: got %0d, expected %0d", $time, what, got, exp);
      cnt_errs++;
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s: got %b, expected %b", $time, what, got, exp);
      flag_errs++;
    end
  endtask

  // raster index of the bottom-right pixel of result n in the whole stream.
  function automatic int win_pixel(int n);
    int g;
    int j;
    g = n / RES_PER_FRM;
    j = n % RES_PER_FRM;
    return g * PIX_PER_FRM + (WIN - 1 + j / OUT_COLS) * IMG_COLS + (WIN - 1 + j % OUT_COLS);
  endfunction

  // opcode driven on the later pixels of a frame, which must be ignored.
  function automatic op_e other_op(op_e op);
    case (op)
      OP_SUM:  return OP_MIN;
      OP_MAX:  return OP_SUM;
      default: return OP_MAX;
    endcase
  endfunction

  task automatic load_cases();
    int base;
    $readmemh("test/window_filter_cases.txt", case_mem);
    for (int f = 0; f < N_FRAMES; f++) begin
      base = f * FRM_WORDS;
      if (case_mem[base] > 2) begin
        $display("cases file: frame %0d does not start with a valid opcode", f);
        other_errs++;
      end
      frame_op[f] = op_e'(case_mem[base][1:0]);
      for (int i = 0; i < PIX_PER_FRM; i++) begin
        frame_pix[f][i] = pix_t'(case_mem[base + 1 + i]);
      end
      for (int i = 0; i < RES_PER_FRM; i++) begin
        frame_exp[f][i] = res_t'(case_mem[base + 1 + PIX_PER_FRM + i]);
      end
    end
  endtask

  // ##################################################
  // stimulus driven on the falling edge.
  // ##################################################
  task automatic drive_pixels();
    int gap;
    for (int p = 0; p < N_PASSES; p++) begin
      stall_on = (p > 0);
      for (int f = 0; f < N_FRAMES; f++) begin
        for (int i = 0; i < PIX_PER_FRM; i++) begin
          gap = 0;
          if (stall_on && ($urandom_range(3, 0) == 0)) gap = int'($urandom_range(3, 1));
          if (gap > 0) begin
            pix_valid_i = 1'b0;
            repeat (gap) @(negedge clk);
          end
          pix_valid_i = 1'b1;
          pix_i       = frame_pix[f][i];
          op_i        = (i == 0) ? frame_op[f] : other_op(frame_op[f]);
          @(posedge clk);
          while (!pix_ready_o) @(posedge clk);  // held until taken.
          @(negedge clk);
        end
      end
    end
    pix_valid_i = 1'b0;
    sent_done   = 1'b1;
  endtask

  task automatic drive_ready();
    while (!done_all) begin
      @(negedge clk);
      if (stall_on) res_ready_i = ($urandom_range(3, 0) != 0);
      else res_ready_i = 1'b1;
    end
    res_ready_i = 1'b1;
  endtask

  task automatic wait_results();
    wait (sent_done);
    while (received < TOTAL_RES) @(negedge clk);
    done_all = 1'b1;
    repeat (2 * WIN + 2) @(negedge clk);  // room for a stray extra result.
  endtask

  // ##################################################
  // result monitor.
  // ##################################################
  task automatic take_result();
    int n;
    int frm;
    n = received;
    if (n >= TOTAL_RES) begin
      $display("unexpected extra result %h after the last frame at time %0t", res_o, $time);
      other_errs++;
    end else begin
      check_flag(accepted > win_pixel(n), 1'b1,
                 $sformatf("result %0d before its window was complete", n));
      check_res(res_o, frame_exp[(n / RES_PER_FRM) % N_FRAMES][n % RES_PER_FRM],
                $sformatf("frame %0d result %0d", n / RES_PER_FRM, n % RES_PER_FRM));
      if (accepted > FIRST_WIN) begin
        frm = (accepted - 1 - FIRST_WIN) / PIX_PER_FRM;
        if (frm < N_STREAM) frame_res[frm]++;
      end
    end
    received++;
  endtask

  initial begin
    accepted = 0;
    received = 0;
    held     = 1'b0;
    held_res = '0;
    for (int g = 0; g < N_STREAM; g++) begin
      frame_res[g] = 0;
    end
    forever begin
      @(posedge clk);
      if (rst_n) begin
        if (held) begin
          check_flag(res_valid_o, 1'b1, "res_valid_o dropped during a stall");
          check_res(res_o, held_res, "res_o changed during a stall");
        end
        if (res_valid_o && res_ready_i) take_result();
        held     = res_valid_o && !res_ready_i;
        held_res = res_o;
        if (pix_valid_i && pix_ready_o) accepted++;
      end
    end
  end

  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d clock cycles", WD_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    rst_n       = 1'b0;
    pix_valid_i = 1'b0;
    pix_i       = '0;
    op_i        = OP_SUM;
    res_ready_i = 1'b0;  // sink not ready, so pix_ready_o shows the output state.
    stall_on    = 1'b0;
    sent_done   = 1'b0;
    done_all    = 1'b0;
    val_errs    = 0;
    cnt_errs    = 0;
    flag_errs   = 0;
    other_errs  = 0;
    void'($urandom(SEED));
    load_cases();

    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    check_flag(res_valid_o, 1'b0, "res_valid_o after reset");
    check_flag(pix_ready_o, 1'b1, "pix_ready_o after reset");
    @(negedge clk);

    fork
      drive_pixels();
      drive_ready();
      wait_results();
    join

    for (int g = 0; g < N_STREAM; g++) begin
      check_count(frame_res[g], RES_PER_FRM, $sformatf("results of frame %0d", g));
    end
    check_count(received, TOTAL_RES, "results in total");

    $display("errors: value %0d, count %0d, flag %0d, other %0d",
             val_errs, cnt_errs, flag_errs, other_errs);
    if ((val_errs + cnt_errs + flag_errs + other_errs) == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/window_filter_cases.txt
// per frame: opcode (0 sum, 1 max, 2 min), six rows of eight pixels,
// then four rows of six expected results, one per full 3x3 window in raster order.
0
80 81 82 83 84 85 86 87
90 91 92 93 94 95 96 97
a0 a1 a2 a3 a4 a5 a6 a7
b0 b1 b2 b3 b4 b5 b6 b7
c0 c1 c2 c3 c4 c5 c6 c7
d0 d1 d2 d3 d4 d5 d6 d7
519 522 52b 534 53d 546
5a9 5b2 5bb 5c4 5cd 5d6
639 642 64b 654 65d 666
6c9 6d2 6db 6e4 6ed 6f6
1
05 3c 12 90 07 22 41 0a
18 01 c8 04 33 09 5e 10
27 66 0b 2d 1f a4 02 77
0e 80 14 3a f0 06 19 2b
50 03 99 08 11 6c 25 0d
13 42 07 b5 2e 01 88 30
0c8 0c8 0c8 0a4 0a4 0a4
0c8 0c8 0f0 0f0 0f0 0a4
099 099 0f0 0f0 0f0 0a4
099 0b5 0f0 0f0 0f0 088
2
80 7f 90 a1 b2 c3 d4 e5
6e 5d 4c 3b 2a 19 08 f7
9a ab bc cd de ef 10 21
32 43 54 65 76 87 98 a9
ff fe 01 fd fc fb 02 fa
44 55 66 77 88 99 aa bb
04c 03b 02a 019 008 008
032 03b 02a 019 008 008
001 001 001 065 002 002
001 001 001 065 002 002

//--- window_filter.f
source/window_filter_pkg.sv
source/window_ctrl.sv
source/line_buffer_bank.sv
source/window_row.sv
source/window_reduce.sv
source/window_filter_top.sv
test/tb_window_filter.sv

//--- run_sim.sh
#!/bin/sh
# build and run the window filter testbench with verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_window_filter -f window_filter.f \
  -o tb_window_filter || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/tb_window_filter)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
